//--- Bender.yml
package:
  name: exec_core

sources:
  - verilog/dual_issue_pkg.sv
  - verilog/inst_decoder.sv
  - verilog/reg_file.sv
  - verilog/issue_ctrl.sv
  - verilog/id_ex.sv
  - verilog/alu.sv
  - verilog/exec_core.sv
  - target: test
    files:
      - verif/tb_exec_core.sv

//--- tb.f
verilog/dual_issue_pkg.sv
verilog/inst_decoder.sv
verilog/reg_file.sv
verilog/issue_ctrl.sv
verilog/id_ex.sv
verilog/alu.sv
verilog/exec_core.sv
verif/tb_exec_core.sv

//--- verif/tb_exec_core.sv
module tb_exec_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEED       = 53859;
    localparam int MAX_CYCLES = 2000; // All tests together take a few hundred cycles.

    typedef struct packed {
        int                        due; // Negative when the arrival cycle is not checked.
        dual_issue_pkg::reg_addr_t waddr;
        dual_issue_pkg::word_t     data;
    } exp_t;

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      in_valid;
    logic                      in_ready;
    logic                      hold;
    dual_issue_pkg::word_t     in_master_inst;
    dual_issue_pkg::word_t     in_slave_inst;
    dual_issue_pkg::wb_t       wb_master;
    dual_issue_pkg::wb_t       wb_slave;
    dual_issue_pkg::reg_addr_t dbg_raddr;
    dual_issue_pkg::word_t     dbg_rdata;
    dual_issue_pkg::word_t     model [dual_issue_pkg::NUM_REGS];
    exp_t                      exp_q [2][$]; // Index 0 queues the master lane.
    exp_t                      head;
    dual_issue_pkg::wb_t       lane_wb;
    int                        cyc = 0;
    logic                      hold_mode = 1'b0;
    string                     test_name = "reset";

    exec_core u_exec_core (.*);

    always #10 clk = ~clk;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic report_mismatch(input string what, input dual_issue_pkg::word_t expected,
                                   input dual_issue_pkg::word_t actual);
        stop_with_failure($sformatf("FAIL %s: %s expected %h actual %h",
                                    test_name, what, expected, actual));
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            stop_with_failure($sformatf("Timeout after %0d cycles in test %s.", cyc, test_name));
        end
    end

    // Evaluates one instruction against the reference registers.
    function automatic void eval_inst(input dual_issue_pkg::word_t inst, output logic wen,
                                      output dual_issue_pkg::reg_addr_t wa,
                                      output dual_issue_pkg::word_t res,
                                      output dual_issue_pkg::reg_addr_t rs,
                                      output dual_issue_pkg::reg_addr_t rt);
        logic                  known;
        dual_issue_pkg::word_t a;
        dual_issue_pkg::word_t b;
        rs    = inst[25:21];
        rt    = inst[20:16];
        a     = model[rs];
        b     = model[rt];
        known = 1'b1;
        wa    = (inst[31:26] == 6'h00) ? inst[15:11] : rt;
        res   = '0;
        case (inst[31:26])
            6'h00: begin
                case (inst[5:0])
                    6'h21:   res = a + b;
                    6'h23:   res = a - b;
                    6'h24:   res = a & b;
                    6'h25:   res = a | b;
                    6'h26:   res = a ^ b;
                    6'h2a:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    6'h00:   res = b << inst[10:6];
                    6'h02:   res = b >> inst[10:6];
                    default: known = 1'b0;
                endcase
            end
            6'h09:   res = a + {{16{inst[15]}}, inst[15:0]};
            6'h0c:   res = a & {16'h0000, inst[15:0]};
            6'h0d:   res = a | {16'h0000, inst[15:0]};
            6'h0f:   res = {inst[15:0], 16'h0000};
            default: known = 1'b0;
        endcase
        wen = known && (wa != '0);
        if (!known) begin
            rs = '0; // A NOP reads nothing.
            rt = '0;
        end
    endfunction

    // Kinds 0 to 7 are ADDU SUBU AND OR XOR SLT SLL SRL, 8 to 11 are ADDIU ANDI ORI LUI.
    function automatic dual_issue_pkg::word_t make_inst(input int kind,
                                                        input dual_issue_pkg::reg_addr_t rs,
                                                        input dual_issue_pkg::reg_addr_t rt,
                                                        input dual_issue_pkg::reg_addr_t rd,
                                                        input logic [15:0] imm);
        logic [5:0] fn_tab [8];
        logic [5:0] op_tab [4];
        fn_tab = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2a, 6'h00, 6'h02};
        op_tab = '{6'h09, 6'h0c, 6'h0d, 6'h0f};
        if (kind < 8) begin
            return {6'h00, rs, rt, rd, imm[4:0], fn_tab[kind]};
        end else begin
            return {op_tab[kind - 8], rs, rt, imm};
        end
    endfunction

    function automatic dual_issue_pkg::reg_addr_t pick_reg(
        input dual_issue_pkg::reg_addr_t avoid
    );
        dual_issue_pkg::reg_addr_t r;
        r = 5'($urandom_range(0, 31));
        return (r == avoid) ? (r ^ 5'd1) : r;
    endfunction

    always @(negedge clk) begin
        if (!rst) begin
            for (int l = 0; l < 2; l++) begin
                lane_wb = (l == 0) ? wb_master : wb_slave;
                if (lane_wb.valid) begin
                    assert (exp_q[l].size() > 0)
                        else stop_with_failure($sformatf("%s: lane %0d wrote back unexpectedly.",
                                                         test_name, l));
                    head = exp_q[l].pop_front();
                    assert (lane_wb.waddr == head.waddr)
                        else report_mismatch("waddr", 32'(head.waddr), 32'(lane_wb.waddr));
                    assert (lane_wb.data == head.data)
                        else report_mismatch("data", head.data, lane_wb.data);
                    assert (head.due < 0 || head.due == cyc)
                        else report_mismatch("write-back cycle", head.due, cyc);
                end else if (exp_q[l].size() > 0) begin
                    assert (exp_q[l][0].due < 0 || exp_q[l][0].due > cyc)
                        else stop_with_failure($sformatf("%s: lane %0d missed a write-back.",
                                                         test_name, l));
                end
            end
        end
    end

    // Offers one pair, waits for it to be taken and queues the expected write-backs.
    task automatic send_pair(input dual_issue_pkg::word_t m_inst,
                             input dual_issue_pkg::word_t s_inst);
        logic                      m_wen;
        logic                      s_wen;
        logic                      dep;
        int                        start;
        dual_issue_pkg::reg_addr_t m_wa;
        dual_issue_pkg::reg_addr_t s_wa;
        dual_issue_pkg::reg_addr_t m_rs;
        dual_issue_pkg::reg_addr_t m_rt;
        dual_issue_pkg::reg_addr_t s_rs;
        dual_issue_pkg::reg_addr_t s_rt;
        dual_issue_pkg::word_t     m_res;
        dual_issue_pkg::word_t     s_res;
        start          = cyc;
        in_valid       = 1'b1;
        in_master_inst = m_inst;
        in_slave_inst  = s_inst;
        eval_inst(m_inst, m_wen, m_wa, m_res, m_rs, m_rt);
        if (m_wen) begin
            model[m_wa] = m_res;
            exp_q[0].push_back(exp_t'{hold_mode ? -1 : start + 2, m_wa, m_res});
        end
        eval_inst(s_inst, s_wen, s_wa, s_res, s_rs, s_rt);
        dep = m_wen && (s_rs == m_wa || s_rt == m_wa);
        @(negedge clk);
        if (!hold_mode) begin
            assert (in_ready == !dep) else report_mismatch("in_ready", 32'(!dep), 32'(in_ready));
        end
        while (!in_ready) @(negedge clk);
        if (s_wen) begin
            model[s_wa] = s_res; // Later in program order, so it wins a clash.
            exp_q[1].push_back(exp_t'{hold_mode ? -1 : start + (dep ? 3 : 2), s_wa, s_res});
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    // Lets the pending write-backs drain, then compares every register with the model.
    task automatic check_regs();
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0) @(negedge clk);
        for (int r = 0; r < dual_issue_pkg::NUM_REGS; r++) begin
            @(posedge clk);
            #2;
            dbg_raddr = 5'(r);
            @(negedge clk);
            assert (dbg_rdata == model[r])
                else report_mismatch($sformatf("register %0d", r), model[r], dbg_rdata);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic reset_values();
        test_name = "reset";
        @(negedge clk);
        assert (in_ready) else report_mismatch("in_ready", 32'd1, 32'(in_ready));
        assert (!wb_master.valid && !wb_slave.valid)
            else report_mismatch("write-back valids", 32'd0, {wb_master.valid, wb_slave.valid});
        check_regs();
    endtask

    task automatic independent_pairs();
        dual_issue_pkg::reg_addr_t d;
        int                        mk;
        int                        sk;
        dual_issue_pkg::word_t     m_inst;
        dual_issue_pkg::word_t     s_inst;
        test_name = "independent";
        for (int i = 0; i < 40; i++) begin
            d      = 5'($urandom_range(1, 31));
            mk     = $urandom_range(0, 11);
            sk     = $urandom_range(0, 11);
            m_inst = make_inst(mk, pick_reg(d), (mk < 8) ? pick_reg(d) : d, d, 16'($urandom));
            s_inst = make_inst(sk, pick_reg(d), pick_reg(d), 5'($urandom), 16'($urandom));
            send_pair(m_inst, s_inst);
        end
        check_regs();
    endtask

    task automatic split_pairs();
        test_name = "split";
        send_pair(make_inst(8, 0, 8, 0, 16'h1234), make_inst(0, 8, 8, 9, 16'h0));   // Reads r8 twice.
        send_pair(make_inst(10, 8, 10, 0, 16'h0f0f), make_inst(1, 9, 10, 11, 16'h0)); // Reads r10.
        check_regs();
    endtask

    task automatic forwarding_waw();
        test_name = "forward_waw";
        send_pair(make_inst(11, 0, 20, 0, 16'h8000), make_inst(10, 0, 21, 0, 16'h00ff));
        send_pair(make_inst(5, 20, 21, 22, 16'h0), make_inst(7, 0, 20, 23, 16'd3));
        send_pair(make_inst(0, 20, 21, 24, 16'h0), make_inst(3, 21, 22, 24, 16'h0)); // Both r24.
        send_pair(make_inst(4, 24, 20, 25, 16'h0), make_inst(8, 24, 26, 0, 16'hffff));
        check_regs();
    endtask

    task automatic zero_and_unknown();
        test_name = "zero_unknown";
        send_pair(make_inst(0, 20, 21, 0, 16'h0), 32'hfc00_0000);
        send_pair(32'h0000_003f, make_inst(8, 21, 0, 0, 16'h0007));
        check_regs();
    endtask

    task automatic hold_release();
        test_name = "hold";
        hold_mode = 1'b1;
        send_pair(make_inst(10, 0, 12, 0, 16'h00f0), make_inst(11, 0, 13, 0, 16'hbeef));
        fork
            begin
                send_pair(make_inst(0, 12, 13, 14, 16'h0), make_inst(1, 13, 12, 15, 16'h0));
                send_pair(make_inst(4, 14, 15, 16, 16'h0), make_inst(6, 0, 15, 17, 16'd4));
            end
            begin
                hold = 1'b1;
                repeat (4) begin
                    @(posedge clk);
                    @(negedge clk);
                    assert (!in_ready && !wb_master.valid && !wb_slave.valid)
                        else stop_with_failure("hold: a pair was taken or written back.");
                end
                @(posedge clk);
                #2;
                hold = 1'b0;
            end
        join
        hold_mode = 1'b0;
        check_regs();
    endtask

    initial begin
        void'($urandom(SEED));
        rst            = 1'b1;
        in_valid       = 1'b0;
        in_master_inst = '0;
        in_slave_inst  = '0;
        hold           = 1'b0;
        dbg_raddr      = '0;
        for (int r = 0; r < dual_issue_pkg::NUM_REGS; r++) begin
            model[r] = '0;
        end
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        reset_values();
        independent_pairs();
        split_pairs();
        forwarding_waw();
        zero_and_unknown();
        hold_release();
        repeat (4) @(negedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- verilog/alu.sv
module alu (
    input  dual_issue_pkg::ex_lane_t lane,
    output dual_issue_pkg::word_t    result
);

    logic lt;

    assign lt = $signed(lane.a) < $signed(lane.b);

    always_comb begin
        case (lane.alu_op)
            dual_issue_pkg::ALU_ADD: result = lane.a + lane.b;
            dual_issue_pkg::ALU_SUB: result = lane.a - lane.b;
            dual_issue_pkg::ALU_AND: result = lane.a & lane.b;
            dual_issue_pkg::ALU_OR:  result = lane.a | lane.b;
            dual_issue_pkg::ALU_XOR: result = lane.a ^ lane.b;
            dual_issue_pkg::ALU_SLT: result = {31'd0, lt};
            dual_issue_pkg::ALU_SLL: result = lane.b << lane.shamt; // Shifts act on rt.
            dual_issue_pkg::ALU_SRL: result = lane.b >> lane.shamt;
            dual_issue_pkg::ALU_LUI: result = lane.b; // Immediate is already in the upper half.
            default:                 result = '0;
        endcase
    end

endmodule

//--- verilog/dual_issue_pkg.sv
package dual_issue_pkg;

    localparam int NUM_REGS = 32;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [3:0]  alu_op_t;

    localparam alu_op_t ALU_ADD = 4'd0;
    localparam alu_op_t ALU_SUB = 4'd1;
    localparam alu_op_t ALU_AND = 4'd2;
    localparam alu_op_t ALU_OR  = 4'd3;
    localparam alu_op_t ALU_XOR = 4'd4;
    localparam alu_op_t ALU_SLT = 4'd5;
    localparam alu_op_t ALU_SLL = 4'd6;
    localparam alu_op_t ALU_SRL = 4'd7;
    localparam alu_op_t ALU_LUI = 4'd8;

    localparam opcode_t OP_SPECIAL = 6'h00; // R-type, operation in funct.
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_ANDI    = 6'h0c;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_LUI     = 6'h0f;

    localparam opcode_t FN_SLL  = 6'h00;
    localparam opcode_t FN_SRL  = 6'h02;
    localparam opcode_t FN_ADDU = 6'h21;
    localparam opcode_t FN_SUBU = 6'h23;
    localparam opcode_t FN_AND  = 6'h24;
    localparam opcode_t FN_OR   = 6'h25;
    localparam opcode_t FN_XOR  = 6'h26;
    localparam opcode_t FN_SLT  = 6'h2a;

    typedef struct packed {
        reg_addr_t rs;
        reg_addr_t rt;
        logic      wen;
        reg_addr_t waddr;
        alu_op_t   alu_op;
        logic      use_imm;
        word_t     imm_value; // Already extended to a full word.
        shamt_t    shamt;
    } dec_lane_t;

    typedef struct packed {
        logic      valid;
        logic      wen;
        reg_addr_t waddr;
        alu_op_t   alu_op;
        word_t     a;
        word_t     b;
        shamt_t    shamt;
    } ex_lane_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t waddr;
        word_t     data;
    } wb_t;

    typedef enum logic {
        ISSUE_PAIR,
        ISSUE_SECOND
    } issue_state_e;

endpackage

//--- verilog/exec_core.sv
module exec_core (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  dual_issue_pkg::word_t     in_master_inst,
    input  dual_issue_pkg::word_t     in_slave_inst,
    input  logic                      hold,
    output dual_issue_pkg::wb_t       wb_master,
    output dual_issue_pkg::wb_t       wb_slave,
    input  dual_issue_pkg::reg_addr_t dbg_raddr,
    output dual_issue_pkg::word_t     dbg_rdata
);

    dual_issue_pkg::dec_lane_t dec_master;
    dual_issue_pkg::dec_lane_t dec_slave;
    dual_issue_pkg::ex_lane_t  d_master;
    dual_issue_pkg::ex_lane_t  d_slave;
    dual_issue_pkg::ex_lane_t  e_master;
    dual_issue_pkg::ex_lane_t  e_slave;
    dual_issue_pkg::word_t     m_rs_val;
    dual_issue_pkg::word_t     m_rt_val;
    dual_issue_pkg::word_t     s_rs_val;
    dual_issue_pkg::word_t     port3_val;
    dual_issue_pkg::word_t     m_result;
    dual_issue_pkg::word_t     s_result;
    dual_issue_pkg::wb_t       wr_master;
    dual_issue_pkg::wb_t       wr_slave;
    dual_issue_pkg::reg_addr_t port3_addr;
    logic                      ena;
    logic                      clear_master;
    logic                      clear_slave;

    function automatic dual_issue_pkg::ex_lane_t build_lane(
        input dual_issue_pkg::dec_lane_t dec,
        input dual_issue_pkg::word_t     rs_val,
        input dual_issue_pkg::word_t     rt_val,
        input logic                      valid
    );
        dual_issue_pkg::ex_lane_t lane;
        lane.valid  = valid;
        lane.wen    = dec.wen;
        lane.waddr  = dec.waddr;
        lane.alu_op = dec.alu_op;
        lane.a      = rs_val;
        lane.b      = dec.use_imm ? dec.imm_value : rt_val;
        lane.shamt  = dec.shamt;
        return lane;
    endfunction

    inst_decoder u_dec_master (.inst(in_master_inst), .dec(dec_master));
    inst_decoder u_dec_slave  (.inst(in_slave_inst),  .dec(dec_slave));

    // The fourth port serves the debug read whenever no pair is offered.
    assign port3_addr = in_valid ? dec_slave.rt : dbg_raddr;
    assign dbg_rdata  = port3_val;

    reg_file u_reg_file (
        .clk(clk), .rst(rst),
        .raddr0(dec_master.rs), .raddr1(dec_master.rt),
        .raddr2(dec_slave.rs),  .raddr3(port3_addr),
        .rdata0(m_rs_val), .rdata1(m_rt_val), .rdata2(s_rs_val), .rdata3(port3_val),
        .wr_master(wr_master), .wr_slave(wr_slave)
    );

    issue_ctrl u_issue_ctrl (
        .clk(clk), .rst(rst), .in_valid(in_valid), .hold(hold),
        .dec_master(dec_master), .dec_slave(dec_slave),
        .in_ready(in_ready), .ena(ena),
        .clear_master(clear_master), .clear_slave(clear_slave)
    );

    assign d_master = build_lane(dec_master, m_rs_val, m_rt_val, in_valid);
    assign d_slave  = build_lane(dec_slave, s_rs_val, port3_val, in_valid);

    id_ex u_id_ex (
        .clk(clk), .rst(rst), .ena(ena),
        .clear_master(clear_master), .clear_slave(clear_slave),
        .d_master(d_master), .d_slave(d_slave),
        .e_master(e_master), .e_slave(e_slave)
    );

    alu u_alu_master (.lane(e_master), .result(m_result));
    alu u_alu_slave  (.lane(e_slave),  .result(s_result));

    assign wr_master = '{valid: e_master.valid && e_master.wen && !hold,
                         waddr: e_master.waddr, data: m_result};
    assign wr_slave  = '{valid: e_slave.valid && e_slave.wen && !hold,
                         waddr: e_slave.waddr, data: s_result};

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_master <= '0;
            wb_slave  <= '0;
        end else begin
            wb_master <= wr_master; // Reported in the cycle after the register write.
            wb_slave  <= wr_slave;
        end
    end

endmodule

//--- verilog/id_ex.sv
module id_ex (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     ena,
    input  logic                     clear_master,
    input  logic                     clear_slave,
    input  dual_issue_pkg::ex_lane_t d_master,
    input  dual_issue_pkg::ex_lane_t d_slave,
    output dual_issue_pkg::ex_lane_t e_master,
    output dual_issue_pkg::ex_lane_t e_slave
);

    // A clear wins over the enable so a bubble is inserted on that lane.
    always_ff @(posedge clk) begin
        if (rst || clear_master) begin
            e_master <= '0;
        end else if (ena) begin
            e_master <= d_master;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear_slave) begin
            e_slave <= '0;
        end else if (ena) begin
            e_slave <= d_slave;
        end
    end

endmodule

//--- verilog/inst_decoder.sv
module inst_decoder (
    input  dual_issue_pkg::word_t     inst,
    output dual_issue_pkg::dec_lane_t dec
);

    dual_issue_pkg::opcode_t opcode;
    dual_issue_pkg::opcode_t funct;
    logic [15:0]             imm;
    logic                    known;

    assign opcode = inst[31:26];
    assign funct  = inst[5:0];
    assign imm    = inst[15:0];

    always_comb begin
        dec       = '0;
        known     = 1'b1;
        dec.rs    = inst[25:21];
        dec.rt    = inst[20:16];
        dec.waddr = inst[20:16]; // I-type writes rt.
        case (opcode)
            dual_issue_pkg::OP_SPECIAL: begin
                dec.waddr = inst[15:11];
                dec.shamt = inst[10:6];
                case (funct)
                    dual_issue_pkg::FN_ADDU: dec.alu_op = dual_issue_pkg::ALU_ADD;
                    dual_issue_pkg::FN_SUBU: dec.alu_op = dual_issue_pkg::ALU_SUB;
                    dual_issue_pkg::FN_AND:  dec.alu_op = dual_issue_pkg::ALU_AND;
                    dual_issue_pkg::FN_OR:   dec.alu_op = dual_issue_pkg::ALU_OR;
                    dual_issue_pkg::FN_XOR:  dec.alu_op = dual_issue_pkg::ALU_XOR;
                    dual_issue_pkg::FN_SLT:  dec.alu_op = dual_issue_pkg::ALU_SLT;
                    dual_issue_pkg::FN_SLL:  dec.alu_op = dual_issue_pkg::ALU_SLL;
                    dual_issue_pkg::FN_SRL:  dec.alu_op = dual_issue_pkg::ALU_SRL;
                    default:                 known = 1'b0;
                endcase
            end
            dual_issue_pkg::OP_ADDIU: begin
                dec.alu_op    = dual_issue_pkg::ALU_ADD;
                dec.use_imm   = 1'b1;
                dec.imm_value = {{16{imm[15]}}, imm};
            end
            dual_issue_pkg::OP_ANDI: begin
                dec.alu_op    = dual_issue_pkg::ALU_AND;
                dec.use_imm   = 1'b1;
                dec.imm_value = {16'h0000, imm};
            end
            dual_issue_pkg::OP_ORI: begin
                dec.alu_op    = dual_issue_pkg::ALU_OR;
                dec.use_imm   = 1'b1;
                dec.imm_value = {16'h0000, imm};
            end
            dual_issue_pkg::OP_LUI: begin
                dec.alu_op    = dual_issue_pkg::ALU_LUI;
                dec.use_imm   = 1'b1;
                dec.imm_value = {imm, 16'h0000};
            end
            default: known = 1'b0;
        endcase
        if (!known) begin
            dec = '0; // A full NOP, so it never looks like a dependency.
        end
        dec.wen = known && (dec.waddr != '0);
    end

endmodule

//--- verilog/issue_ctrl.sv
module issue_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  logic                      hold,
    input  dual_issue_pkg::dec_lane_t dec_master,
    input  dual_issue_pkg::dec_lane_t dec_slave,
    output logic                      in_ready,
    output logic                      ena,
    output logic                      clear_master,
    output logic                      clear_slave
);

    dual_issue_pkg::issue_state_e state;
    dual_issue_pkg::issue_state_e state_next;
    logic                         dep;

    // The slave reads what the master is about to write.
    assign dep = dec_master.wen &&
                 ((dec_slave.rs == dec_master.waddr) || (dec_slave.rt == dec_master.waddr));

    assign ena = !hold;

    always_comb begin
        state_next   = state;
        in_ready     = 1'b0;
        clear_master = 1'b0;
        clear_slave  = 1'b0;
        if (!hold) begin
            if (!in_valid) begin
                clear_master = 1'b1;
                clear_slave  = 1'b1;
                in_ready     = 1'b1;
            end else if (state == dual_issue_pkg::ISSUE_SECOND) begin
                clear_master = 1'b1; // Master went out last cycle.
                in_ready     = 1'b1;
                state_next   = dual_issue_pkg::ISSUE_PAIR;
            end else if (dep) begin
                clear_slave = 1'b1;
                state_next  = dual_issue_pkg::ISSUE_SECOND;
            end else begin
                in_ready = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dual_issue_pkg::ISSUE_PAIR;
        end else begin
            state <= state_next;
        end
    end

endmodule

//--- verilog/reg_file.sv
module reg_file (
    input  logic                      clk,
    input  logic                      rst,
    input  dual_issue_pkg::reg_addr_t raddr0,
    input  dual_issue_pkg::reg_addr_t raddr1,
    input  dual_issue_pkg::reg_addr_t raddr2,
    input  dual_issue_pkg::reg_addr_t raddr3,
    output dual_issue_pkg::word_t     rdata0,
    output dual_issue_pkg::word_t     rdata1,
    output dual_issue_pkg::word_t     rdata2,
    output dual_issue_pkg::word_t     rdata3,
    input  dual_issue_pkg::wb_t       wr_master,
    input  dual_issue_pkg::wb_t       wr_slave
);

    dual_issue_pkg::word_t regs [dual_issue_pkg::NUM_REGS];

    // Slave is later in program order, so its write is checked first.
    function automatic dual_issue_pkg::word_t read_port(
        input dual_issue_pkg::reg_addr_t addr
    );
        dual_issue_pkg::word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wr_slave.valid && wr_slave.waddr == addr) begin
            value = wr_slave.data;
        end else if (wr_master.valid && wr_master.waddr == addr) begin
            value = wr_master.data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < dual_issue_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr_master.valid && wr_master.waddr != '0) begin
                regs[wr_master.waddr] <= wr_master.data;
            end
            if (wr_slave.valid && wr_slave.waddr != '0) begin
                regs[wr_slave.waddr] <= wr_slave.data; // Wins a same-register clash.
            end
        end
    end

    always_comb begin
        rdata0 = read_port(raddr0);
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
        rdata3 = read_port(raddr3);
    end

endmodule
